//--- rename_core.f
+incdir+.
rename_pkg.sv
map_table.sv
free_list.sv
reorder_buffer.sv
phys_regfile.sv
rename_core.sv
tb_clock.sv
rename_core_tb.sv

//--- Makefile
# Verilator build and run of the rename core testbench
BIN  := obj_dir/Vrename_core_tb
SRCS := $(shell grep -v '^+' rename_core.f)

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^TEST OK$$" sim.log

# rebuilt only when a source, the header or the file list changes
$(BIN): $(SRCS) rename_settings.svh rename_core.f
	verilator --binary --timing --assert -j 0 -f rename_core.f \
		--top-module rename_core_tb -o Vrename_core_tb

clean:
	rm -rf obj_dir sim.log

//--- rename_core_tb.sv
// random dispatch and completion traffic for rename_core, checked against a model
// the model holds both maps and an in-order queue of accepted instructions
// inputs change on the falling edge and outputs are sampled 1 ns later
// with ROB_DEPTH in flight the free list cannot run empty, so ready follows the buffer
`include "rename_settings.svh"
`default_nettype none

module rename_core_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import rename_pkg::*;

	localparam int N_PLAIN     = 300;               // dispatches without mispredicts
	localparam int N_BURST     = `ROB_DEPTH + 4;    // overfills the buffer
	localparam int N_MISP      = 400;
	localparam int CYCLE_LIMIT = 20 * (N_PLAIN + N_BURST + N_MISP) + 200;

	// one accepted instruction as the model sees it
	typedef struct packed {
		rob_idx_t  rob_idx;
		arch_idx_t dest;
		phys_idx_t tag;
		logic      done;
		data_t     value;
		logic      mispredict;
	} inflight_t;

	logic      clock;
	logic      rst_n;
	logic      disp_valid;
	logic      disp_ready;
	logic      cmpl_valid;
	logic      commit_valid;
	dispatch_t disp;
	rename_t   disp_tag;
	complete_t cmpl;
	commit_t   commit;

	inflight_t q [$];                  // in program order with the head at index 0
	phys_idx_t spec_m [`ARCH_REGS];    // speculative map
	phys_idx_t ret_m  [`ARCH_REGS];    // retirement map
	dispatch_t pend;                   // held until accepted
	logic      have_pend;
	logic      saw_stall;
	int        cycles, seq, generated, accepted, committed, flushes, zero_commits;
	int        test_no, test_errors, errors, failed_tests;

	tb_clock clk_i (.clock(clock), .rst_n(rst_n));

	rename_core dut_i (
		.clock(clock), .rst_n(rst_n),
		.disp_valid(disp_valid), .disp(disp), .disp_ready(disp_ready), .disp_tag(disp_tag),
		.cmpl_valid(cmpl_valid), .cmpl(cmpl),
		.commit_valid(commit_valid), .commit(commit)
	);

	////////////////////
	// checks
	////////////////////
	task automatic expect_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		assert (got === exp) else begin
			$display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, exp);
			test_errors++;
		end
	endtask

	// tag named by either map or by an in-flight destination
	function automatic logic tag_is_live(input phys_idx_t t);
		logic live;
		live = 1'b0;
		for (int i = 0; i < `ARCH_REGS; i++)
			if (spec_m[i] == t || ret_m[i] == t)
				live = 1'b1;
		foreach (q[i])
			if (q[i].dest != arch_idx_t'(`ZERO_REG) && q[i].tag == t)
				live = 1'b1;
		return live;
	endfunction

	task automatic check_rename();
		expect_eq(64'(disp_tag.src_tag), 64'(spec_m[disp.src]), "source tag");
		if (disp.dest != arch_idx_t'(`ZERO_REG)) begin
			assert (!tag_is_live(disp_tag.dest_tag)) else begin
				$display("ERROR %0t: destination tag %0d is still live", $time, disp_tag.dest_tag);
				test_errors++;
			end
		end
		foreach (q[i])
			assert (q[i].rob_idx != disp_tag.rob_idx) else begin
				$display("ERROR %0t: rob slot %0d handed out twice", $time, disp_tag.rob_idx);
				test_errors++;
			end
	endtask

	task automatic check_commit(input inflight_t h);
		expect_eq(64'(commit.dest), 64'(h.dest), "commit dest");
		expect_eq(64'(commit.wr_en), 64'(h.dest != arch_idx_t'(`ZERO_REG)), "commit wr_en");
		if (h.dest != arch_idx_t'(`ZERO_REG))
			expect_eq(commit.value, h.value, "commit value");
		else
			expect_eq(commit.value, 64'd0, "zero register commit value");   // reads as zero
		expect_eq(64'(commit.mispredict), 64'(h.mispredict), "commit mispredict");
	endtask

	////////////////////
	// one clock cycle
	////////////////////
	task automatic run_cycle(input logic offer_disp, input logic offer_cmpl, input int odds);
		int        open_idx [$];
		logic      exp_cv;
		logic      exp_ready;
		logic      took;
		inflight_t h;
		@(negedge clock);
		if (offer_disp && !have_pend) begin
			pend.dest = ($urandom % 8 == 0) ? arch_idx_t'(`ZERO_REG)
			                                : arch_idx_t'($urandom % `ARCH_REGS);
			pend.src  = arch_idx_t'($urandom % `ARCH_REGS);
			pend.pc   = 64'(generated) << 2;
			have_pend = 1'b1;
			generated++;
		end
		disp_valid = offer_disp && have_pend;
		disp       = pend;
		cmpl_valid = 1'b0;
		foreach (q[i])
			if (!q[i].done)
				open_idx.push_back(i);
		if (offer_cmpl && open_idx.size() != 0 && $urandom % 2 == 0) begin
			h               = q[open_idx[$urandom_range(0, open_idx.size() - 1)]];   // any order
			cmpl.rob_idx    = h.rob_idx;
			cmpl.value      = {$urandom, 32'(seq)};   // low half keeps values unique
			cmpl.mispredict = (odds != 0) && ($urandom % odds == 0);
			cmpl_valid      = 1'b1;
			seq++;
		end
		#1;
		exp_cv    = q.size() != 0 && q[0].done;
		exp_ready = q.size() < `ROB_DEPTH && !(exp_cv && q[0].mispredict);
		expect_eq(64'(commit_valid), 64'(exp_cv), "commit_valid");
		expect_eq(64'(disp_ready), 64'(exp_ready), "disp_ready");
		if (!disp_ready)
			saw_stall = 1'b1;
		if (commit_valid)
			committed++;
		if (exp_cv && commit_valid)
			check_commit(q[0]);
		took = disp_valid && disp_ready;
		if (took)
			check_rename();
		@(posedge clock);
		// commit first, completion next and dispatch last
		if (exp_cv) begin
			h = q.pop_front();
			if (h.dest != arch_idx_t'(`ZERO_REG))
				ret_m[h.dest] = h.tag;
			else
				zero_commits++;
			if (h.mispredict) begin
				q.delete();        // younger entries gone
				spec_m = ret_m;
				flushes++;
			end
		end
		if (cmpl_valid)
			foreach (q[i])
				if (q[i].rob_idx == cmpl.rob_idx && !q[i].done) begin
					q[i].done       = 1'b1;
					q[i].value      = cmpl.value;
					q[i].mispredict = cmpl.mispredict;
				end
		if (took) begin
			q.push_back('{rob_idx: disp_tag.rob_idx, dest: disp.dest, tag: disp_tag.dest_tag,
			              done: 1'b0, value: '0, mispredict: 1'b0});
			if (disp.dest != arch_idx_t'(`ZERO_REG))
				spec_m[disp.dest] = disp_tag.dest_tag;
			accepted++;
			have_pend = 1'b0;
		end
	endtask

	task automatic drain(input int odds);
		while (q.size() != 0 || have_pend)
			run_cycle(have_pend, 1'b1, odds);   // held instruction still goes in
	endtask

	task automatic run_traffic(input int n, input int odds);
		int start;
		start = accepted;
		while (accepted < start + n)
			run_cycle(1'b1, 1'b1, odds);
		drain(odds);
	endtask

	task automatic finish_test(input string name);
		test_no++;
		errors += test_errors;
		if (test_errors != 0)
			failed_tests++;
		$display("test %0d %s: %s, %0d errors", test_no, name,
		         (test_errors == 0) ? "passed" : "failed", test_errors);
		test_errors = 0;
	endtask

	////////////////////
	// test sequence
	////////////////////
	initial begin
		void'($urandom(32'hf7ad33d3));
		disp_valid = 1'b0;
		disp       = '0;
		cmpl_valid = 1'b0;
		cmpl       = '0;
		pend       = '0;
		have_pend  = 1'b0;
		saw_stall  = 1'b0;
		for (int i = 0; i < `ARCH_REGS; i++) begin
			spec_m[i] = phys_idx_t'(i);   // identity at reset
			ret_m[i]  = phys_idx_t'(i);
		end
		wait (rst_n === 1'b1);
		#1;
		expect_eq(64'(disp_ready), 64'd1, "disp_ready after reset");
		expect_eq(64'(commit_valid), 64'd0, "commit_valid after reset");
		finish_test("reset");

		run_traffic(N_PLAIN, 0);
		assert (zero_commits != 0) else begin
			$display("no instruction with the zero register as destination was committed");
			test_errors++;
		end
		finish_test("rename and in-order commit");

		// no completions, so the buffer fills and stalls
		saw_stall = 1'b0;
		repeat (N_BURST) run_cycle(1'b1, 1'b0, 0);
		assert (saw_stall && q.size() == `ROB_DEPTH) else begin
			$display("disp_ready did not fall with the reorder buffer full");
			test_errors++;
		end
		drain(0);
		assert (committed == accepted) else begin
			$display("instructions were lost or duplicated under back-pressure");
			test_errors++;
		end
		finish_test("back-pressure");

		run_traffic(N_MISP, 16);
		assert (flushes != 0) else begin
			$display("no mispredicted commit happened, flush path untested");
			test_errors++;
		end
		finish_test("mispredict flush");

		$display("tests %0d, failed %0d, errors %0d, committed %0d, flushes %0d",
		         test_no, failed_tests, errors, committed, flushes);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// cycle limit
	always @(posedge clock) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles without finishing the tests", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tb_clock.sv
// clock and reset for the rename core testbench
// 4 ns period, rst_n held low for 5 rising edges and released on a falling edge
`default_nettype none

module tb_clock (
	output logic clock,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clock);
		@(negedge clock);   // released where the other inputs change
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- rename_core.sv
// rename and retire core, one dispatch and one commit per cycle
// dispatch is accepted when disp_valid and disp_ready are high at a rising edge
// commit_valid is combinational and the commit takes effect at the next edge
// a ZERO_REG destination parks its result in the zero register's own physical slot
`include "rename_settings.svh"
`default_nettype none

module rename_core (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  disp_valid,
	input  rename_pkg::dispatch_t disp,
	output logic                  disp_ready,
	output rename_pkg::rename_t   disp_tag,
	input  logic                  cmpl_valid,
	input  rename_pkg::complete_t cmpl,
	output logic                  commit_valid,
	output rename_pkg::commit_t   commit
);
	import rename_pkg::*;

	logic                       rob_not_full;
	logic                       fl_not_empty;
	logic                       flush;          // mispredicted commit this cycle
	logic                       accept;
	logic                       rename_en;      // accepted with a real destination
	logic                       live_dest;      // head writes an architectural register
	logic                       retire_en;
	rob_idx_t                   rob_idx;
	phys_idx_t                  src_tag;
	phys_idx_t                  alloc_tag;
	phys_idx_t                  dest_tag;
	phys_idx_t                  replaced_tag;
	phys_idx_t                  wr_tag;
	phys_idx_t [`ARCH_REGS-1:0] arch_map_next;
	rob_entry_t                 head_entry;
	data_t                      rd_data;

	////////////////////
	// dispatch side
	////////////////////
	assign disp_ready = rob_not_full && fl_not_empty && !flush;
	assign accept     = disp_valid && disp_ready;
	assign rename_en  = accept && (disp.dest != arch_idx_t'(`ZERO_REG));
	// zero register never leaves its reset slot
	assign dest_tag   = (disp.dest != arch_idx_t'(`ZERO_REG)) ? alloc_tag
	                                                           : phys_idx_t'(`ZERO_REG);
	assign disp_tag   = '{rob_idx: rob_idx, dest_tag: dest_tag, src_tag: src_tag};

	////////////////////
	// commit side
	////////////////////
	assign live_dest = head_entry.dest != arch_idx_t'(`ZERO_REG);
	assign retire_en = commit_valid && live_dest;
	assign commit    = '{dest: head_entry.dest, wr_en: live_dest,
	                     value: live_dest ? rd_data : '0, mispredict: head_entry.mispredict};

	map_table map_table_i (
		.clock(clock), .rst_n(rst_n),
		.lookup_src(disp.src), .src_tag(src_tag),
		.alloc_en(rename_en), .alloc_dest(disp.dest), .alloc_tag(alloc_tag),
		.retire_en(retire_en), .retire_dest(head_entry.dest), .retire_tag(head_entry.tag),
		.flush(flush), .replaced_tag(replaced_tag), .arch_map_next(arch_map_next)
	);

	free_list free_list_i (
		.clock(clock), .rst_n(rst_n),
		.alloc_en(rename_en), .alloc_tag(alloc_tag), .not_empty(fl_not_empty),
		.release_en(retire_en), .release_tag(replaced_tag),   // old mapping goes back
		.flush(flush), .arch_map_next(arch_map_next)
	);

	reorder_buffer rob_i (
		.clock(clock), .rst_n(rst_n),
		.disp_en(accept), .disp_dest(disp.dest), .disp_tag_in(dest_tag),
		.rob_idx(rob_idx), .not_full(rob_not_full),
		.cmpl_valid(cmpl_valid), .cmpl(cmpl), .wr_tag(wr_tag),
		.head_valid(commit_valid), .head_entry(head_entry), .flush(flush)
	);

	// completions to entries flushed at this edge are dropped
	phys_regfile prf_i (
		.clock(clock), .rst_n(rst_n),
		.wr_en(cmpl_valid && !flush), .wr_tag(wr_tag), .wr_data(cmpl.value),
		.rd_tag(head_entry.tag), .rd_data(rd_data)
	);

endmodule

`default_nettype wire

//--- phys_regfile.sv
// physical register values
// one synchronous write port and one asynchronous read port
// all values clear to zero on reset
`include "rename_settings.svh"
`default_nettype none

module phys_regfile (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  wr_en,
	input  rename_pkg::phys_idx_t wr_tag,
	input  rename_pkg::data_t     wr_data,
	input  rename_pkg::phys_idx_t rd_tag,
	output rename_pkg::data_t     rd_data
);
	import rename_pkg::*;

	data_t regs [`PHYS_REGS];

	assign rd_data = regs[rd_tag];   // commit value, written at least a cycle before

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `PHYS_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_tag] <= wr_data;   // completion result
		end
	end

endmodule

`default_nettype wire

//--- reorder_buffer.sv
// circular buffer of in-flight instructions, one push and one pop per cycle
// the head pops once it is marked done
// a done head with a mispredict flushes the buffer at the commit edge
// completions must target outstanding slots, each at most once
`include "rename_settings.svh"
`default_nettype none

module reorder_buffer (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   disp_en,
	input  rename_pkg::arch_idx_t  disp_dest,
	input  rename_pkg::phys_idx_t  disp_tag_in,
	output rename_pkg::rob_idx_t   rob_idx,
	output logic                   not_full,
	input  logic                   cmpl_valid,
	input  rename_pkg::complete_t  cmpl,
	output rename_pkg::phys_idx_t  wr_tag,
	output logic                   head_valid,
	output rename_pkg::rob_entry_t head_entry,
	output logic                   flush
);
	import rename_pkg::*;

	typedef logic [$clog2(`ROB_DEPTH):0] count_t;   // one bit wider to hold a full buffer

	rob_entry_t entries [`ROB_DEPTH];   // slot payload
	rob_idx_t   head;                   // oldest instruction
	rob_idx_t   tail;                   // next slot to fill
	count_t     count;                  // occupied slots
	rob_idx_t   cmpl_ofs;               // completion slot counted from the head

	////////////////////
	// status
	////////////////////
	assign rob_idx    = tail;
	assign not_full   = count != count_t'(`ROB_DEPTH);
	assign head_entry = entries[head];
	assign head_valid = (count != '0) && entries[head].done;
	assign flush      = head_valid && entries[head].mispredict;
	assign wr_tag     = entries[cmpl.rob_idx].tag;   // register file target of a completion
	assign cmpl_ofs   = cmpl.rob_idx - head;         // wraps with the pointers

	////////////////////
	// pointers
	////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else if (flush) begin
			// mispredicted head retires, everything younger is dropped
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (disp_en)
				tail <= tail + rob_idx_t'(1);
			if (head_valid)
				head <= head + rob_idx_t'(1);   // commit
			count <= count + count_t'(disp_en) - count_t'(head_valid);
		end
	end

	////////////////////
	// slot contents
	////////////////////
	// flags are cleared on allocation, slots past count are never read
	always_ff @(posedge clock) begin
		if (disp_en)
			entries[tail] <= '{dest: disp_dest, tag: disp_tag_in, done: 1'b0, mispredict: 1'b0};
		if (cmpl_valid) begin
			entries[cmpl.rob_idx].done       <= 1'b1;
			entries[cmpl.rob_idx].mispredict <= cmpl.mispredict;
		end
	end

	// a completion lands between head and tail
	a_cmpl_outstanding: assert property (@(posedge clock) disable iff (!rst_n)
		cmpl_valid |-> count_t'(cmpl_ofs) < count);

endmodule

`default_nettype wire

//--- free_list.sv
// free physical register bitmap
// hands out the lowest free tag in the same cycle it is asked for
// a flush frees every tag that the retirement map does not hold
`include "rename_settings.svh"
`default_nettype none

module free_list (
	input  logic                                   clock,
	input  logic                                   rst_n,
	input  logic                                   alloc_en,
	output rename_pkg::phys_idx_t                  alloc_tag,
	output logic                                   not_empty,
	input  logic                                   release_en,
	input  rename_pkg::phys_idx_t                  release_tag,
	input  logic                                   flush,
	input  rename_pkg::phys_idx_t [`ARCH_REGS-1:0] arch_map_next
);
	import rename_pkg::*;

	logic [`PHYS_REGS-1:0] free_bits;   // set = available
	logic [`PHYS_REGS-1:0] held;        // tags named by the retirement map

	// priority pick, scan from the top so the lowest set bit is written last
	always_comb begin
		alloc_tag = '0;
		for (int p = `PHYS_REGS - 1; p >= 0; p--)
			if (free_bits[p])
				alloc_tag = phys_idx_t'(p);
	end

	assign not_empty = |free_bits;

	always_comb begin
		held = '0;
		for (int i = 0; i < `ARCH_REGS; i++)
			held[arch_map_next[i]] = 1'b1;
	end

	////////////////////
	// bitmap update
	////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int p = 0; p < `PHYS_REGS; p++)
				free_bits[p] <= (p >= `ARCH_REGS);   // upper half starts free
		end else if (flush) begin
			free_bits <= ~held;   // also covers the tag released by this commit
		end else begin
			if (alloc_en)
				free_bits[alloc_tag] <= 1'b0;
			if (release_en)
				free_bits[release_tag] <= 1'b1;
		end
	end

	// dispatch is stalled while the list is empty
	a_alloc_not_empty: assert property (@(posedge clock) disable iff (!rst_n)
		alloc_en |-> not_empty);

	// replaced tag from the map table must still be in use
	a_no_double_free: assert property (@(posedge clock) disable iff (!rst_n)
		release_en |-> !free_bits[release_tag]);

endmodule

`default_nettype wire

//--- map_table.sv
// speculative and retirement register maps
// both maps come out of reset as the identity mapping
// a flush loads the retirement map, with this cycle's commit applied, into the speculative map
// the caller keeps ZERO_REG away from both write ports
`include "rename_settings.svh"
`default_nettype none

module map_table (
	input  logic                                   clock,
	input  logic                                   rst_n,
	input  rename_pkg::arch_idx_t                  lookup_src,
	output rename_pkg::phys_idx_t                  src_tag,
	input  logic                                   alloc_en,
	input  rename_pkg::arch_idx_t                  alloc_dest,
	input  rename_pkg::phys_idx_t                  alloc_tag,
	input  logic                                   retire_en,
	input  rename_pkg::arch_idx_t                  retire_dest,
	input  rename_pkg::phys_idx_t                  retire_tag,
	input  logic                                   flush,
	output rename_pkg::phys_idx_t                  replaced_tag,
	output rename_pkg::phys_idx_t [`ARCH_REGS-1:0] arch_map_next
);
	import rename_pkg::*;

	phys_idx_t [`ARCH_REGS-1:0] spec_map;   // view seen at dispatch
	phys_idx_t [`ARCH_REGS-1:0] arch_map;   // view of committed state

	////////////////////
	// lookups
	////////////////////
	assign src_tag      = spec_map[lookup_src];   // old mapping even when src equals dest
	assign replaced_tag = arch_map[retire_dest];  // the commit hands this one back

	// retirement map as it will be after this edge
	always_comb begin
		arch_map_next = arch_map;
		if (retire_en)
			arch_map_next[retire_dest] = retire_tag;
	end

	////////////////////
	// map state
	////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `ARCH_REGS; i++) begin
				spec_map[i] <= phys_idx_t'(i);   // arch i lives in phys i
				arch_map[i] <= phys_idx_t'(i);
			end
		end else begin
			arch_map <= arch_map_next;
			if (flush)
				spec_map <= arch_map_next;  // drop every younger rename
			else if (alloc_en)
				spec_map[alloc_dest] <= alloc_tag;
		end
	end

	// zero register keeps its reset mapping in both tables
	a_zero_reg_fixed: assert property (@(posedge clock) disable iff (!rst_n)
		!(alloc_en && alloc_dest == arch_idx_t'(`ZERO_REG)) &&
		!(retire_en && retire_dest == arch_idx_t'(`ZERO_REG)));

endmodule

`default_nettype wire

//--- rename_pkg.sv
// shared index types and bus structs of the rename core
// all widths derive from the settings macros
`include "rename_settings.svh"
`default_nettype none

package rename_pkg;

	////////////////////
	// index types
	////////////////////
	typedef logic [$clog2(`ARCH_REGS)-1:0] arch_idx_t;   // 5 bits
	typedef logic [$clog2(`PHYS_REGS)-1:0] phys_idx_t;   // 6 bits
	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;    // 4 bits
	typedef logic [`DATA_W-1:0]            data_t;

	////////////////////
	// port structs
	////////////////////
	typedef struct packed {
		arch_idx_t   dest;        // ZERO_REG when nothing is written
		arch_idx_t   src;
		logic [63:0] pc;          // carried for tracing
	} dispatch_t;

	typedef struct packed {
		rob_idx_t  rob_idx;       // slot given to the instruction
		phys_idx_t dest_tag;      // new tag of dest, meaningless for ZERO_REG
		phys_idx_t src_tag;       // current tag of src
	} rename_t;

	typedef struct packed {
		rob_idx_t rob_idx;
		data_t    value;
		logic     mispredict;     // flush younger entries once this one retires
	} complete_t;

	typedef struct packed {
		arch_idx_t dest;
		logic      wr_en;         // low for ZERO_REG
		data_t     value;
		logic      mispredict;
	} commit_t;

	// one reorder buffer slot
	typedef struct packed {
		arch_idx_t dest;
		phys_idx_t tag;
		logic      done;
		logic      mispredict;
	} rob_entry_t;

endpackage

`default_nettype wire

//--- rename_settings.svh
// sizes shared by every block of the rename core
// ROB_DEPTH must be a power of two because the buffer pointers wrap on overflow
// PHYS_REGS must exceed ARCH_REGS
// tags 0 to ARCH_REGS-1 hold the reset mapping
// ZERO_REG is never renamed and reads as zero at commit
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

////////////////////
// register files
////////////////////
`define ARCH_REGS 32    // architectural registers
`define PHYS_REGS 64    // physical registers, one value each

////////////////////
// buffers and data
////////////////////
`define ROB_DEPTH 16    // in-flight instructions
`define DATA_W    64    // result width

// architectural register that is never renamed
`define ZERO_REG  31

`endif
